/* vlog.f */
nav_pkg.sv
nav_config.sv
nav_integrator.sv
nav_rotator.sv
nav_sequencer.sv
nav_top.sv
nav_chk.sv
nav_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the nav_top testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module nav_tb -f vlog.f -o nav_sim

./obj_dir/nav_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "run.sh: simulation ended without a pass result"
    exit 1
fi

/* nav_tb.sv */
`timescale 1ns/1ps

module nav_tb;

    import nav_pkg::*;

    localparam int  NUM_RANDOM     = 30;
    localparam int  NUM_DT         = 20;
    localparam int  NUM_EXTRA      = 4;
    localparam int  TIMEOUT_CYCLES = 20 * (NUM_RANDOM + NUM_DT + NUM_EXTRA) + 200;
    localparam int  SPACING        = 8;
    localparam dt_t DT_INIT        = 16'd1;
    localparam dt_t DT_LARGE       = 16'd16384;

    logic        clk;
    logic        rst;
    logic        sample_valid;
    sample_t     acc_x;
    sample_t     acc_y;
    sample_t     gyro_z;
    logic        cfg_wr;
    logic        cfg_addr;
    logic [15:0] cfg_data;
    logic        busy;
    logic        update_done;
    accum_t      heading;
    accum_t      vel_x;
    accum_t      vel_y;
    accum_t      pos_x;
    accum_t      pos_y;

    // Model state
    accum_t      m_heading;
    accum_t      m_vel_x;
    accum_t      m_vel_y;
    accum_t      m_pos_x;
    accum_t      m_pos_y;
    dt_t         m_dt;
    logic [15:0] sector_seen;

    // Expected published sets in arrival order
    accum_t      exp_heading[$];
    accum_t      exp_vel_x[$];
    accum_t      exp_vel_y[$];
    accum_t      exp_pos_x[$];
    accum_t      exp_pos_y[$];

    int          done_count  = 0;
    int          cycle_count = 0;
    bit          run_done    = 1'b0;
    bit          fail_seen   = 1'b0;

    nav_top #(.DT_RESET(DT_INIT)) dut_i (
        .clk(clk), .rst(rst), .sample_valid(sample_valid),
        .acc_x(acc_x), .acc_y(acc_y), .gyro_z(gyro_z),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .busy(busy), .update_done(update_done), .heading(heading),
        .vel_x(vel_x), .vel_y(vel_y), .pos_x(pos_x), .pos_y(pos_y)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string what);
        fail_seen = 1'b1;
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR at time %0t: %s is %0d (0x%08h), expected %0d (0x%08h)",
                               $time, name, $signed(actual), actual,
                               $signed(expected), expected));
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles, the DUT stopped responding",
                               cycle_count));
        end
    end

    final begin
        if (!run_done && !fail_seen) begin
            $display("Run ended before all checks completed");
            $display("Simulation FAILED");
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Entry k is 2^14 times sin(k * 22.5 deg) rounded to nearest
    function automatic int sin_entry(input int k);
        real s;
        s = real'(1 << TRIG_FRAC_BITS) * $sin(3.14159265358979 * k / 8.0);
        return (s >= 0.0) ? $rtoi(s + 0.5) : $rtoi(s - 0.5);
    endfunction

    function automatic void nav_model(input sample_t ax, input sample_t ay, input sample_t gz);
        longint d;
        longint prod;
        longint rx;
        longint ry;
        int     sec;
        int     s;
        int     c;
        d = m_dt;
        prod = longint'(gz) * d;
        m_heading = m_heading + prod[31:0];
        sec = m_heading[31:28];
        sector_seen[sec] = 1'b1;
        s = sin_entry(sec);
        c = sin_entry((sec + 4) % 16);
        rx = (longint'(ax) * c - longint'(ay) * s) >>> TRIG_FRAC_BITS;
        ry = (longint'(ax) * s + longint'(ay) * c) >>> TRIG_FRAC_BITS;
        prod = rx * d;
        m_vel_x = m_vel_x + prod[31:0];
        prod = ry * d;
        m_vel_y = m_vel_y + prod[31:0];
        // Position uses the velocity just updated
        prod = longint'(m_vel_x) * d;
        m_pos_x = m_pos_x + prod[31:0];
        prod = longint'(m_vel_y) * d;
        m_pos_y = m_pos_y + prod[31:0];
        exp_heading.push_back(m_heading);
        exp_vel_x.push_back(m_vel_x);
        exp_vel_y.push_back(m_vel_y);
        exp_pos_x.push_back(m_pos_x);
        exp_pos_y.push_back(m_pos_y);
    endfunction

    // Compare each published set at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (update_done === 1'b1) begin
                if (exp_heading.size() == 0) begin
                    fail_run("update_done pulsed with no accepted sample outstanding");
                end else begin
                    check_value("heading", heading, exp_heading.pop_front());
                    check_value("vel_x", vel_x, exp_vel_x.pop_front());
                    check_value("vel_y", vel_y, exp_vel_y.pop_front());
                    check_value("pos_x", pos_x, exp_pos_x.pop_front());
                    check_value("pos_y", pos_y, exp_pos_y.pop_front());
                    done_count = done_count + 1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks that enter and leave just after a rising edge
    ////////////////////////////////////////////////////////////

    function automatic sample_t random_sample();
        logic [31:0] r;
        r = $urandom();
        return r[15:0];
    endfunction

    task automatic cfg_write(input logic addr, input logic [15:0] data);
        cfg_wr   <= 1'b1;
        cfg_addr <= addr;
        cfg_data <= data;
        @(posedge clk);
        cfg_wr   <= 1'b0;
        @(posedge clk);
    endtask

    task automatic drive_sample(input sample_t ax, input sample_t ay, input sample_t gz);
        sample_valid <= 1'b1;
        acc_x        <= ax;
        acc_y        <= ay;
        gyro_z       <= gz;
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    task automatic wait_for_done(input int target, inout int waited);
        while (done_count < target) begin
            @(posedge clk);
            waited = waited + 1;
        end
        while (waited < SPACING) begin
            @(posedge clk);
            waited = waited + 1;
        end
    endtask

    task automatic run_sample(input sample_t ax, input sample_t ay, input sample_t gz);
        int target;
        int waited;
        target = done_count + 1;
        drive_sample(ax, ay, gz);
        nav_model(ax, ay, gz);
        waited = 1;
        wait_for_done(target, waited);
    endtask

    task automatic check_published_zero();
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("update_done", update_done, 0);
        check_value("heading", heading, 0);
        check_value("vel_x", vel_x, 0);
        check_value("vel_y", vel_y, 0);
        check_value("pos_x", pos_x, 0);
        check_value("pos_y", pos_y, 0);
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int target;
        int waited;
        sample_t gz;
        void'($urandom(32'hf47bc4dc));
        rst          = 1'b1;
        sample_valid = 1'b0;
        acc_x        = '0;
        acc_y        = '0;
        gyro_z       = '0;
        cfg_wr       = 1'b0;
        cfg_addr     = 1'b0;
        cfg_data     = '0;
        m_heading    = '0;
        m_vel_x      = '0;
        m_vel_y      = '0;
        m_pos_x      = '0;
        m_pos_y      = '0;
        m_dt         = DT_INIT;
        sector_seen  = '0;

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Reset state and a sample while disabled
        check_published_zero();
        drive_sample(random_sample(), random_sample(), random_sample());
        repeat (12) @(posedge clk);
        check_published_zero();

        // Enabled with the reset dt
        cfg_write(1'b1, 16'h0001);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_sample(random_sample(), random_sample(), random_sample());
        end

        // Larger dt moves heading about one sector per sample
        cfg_write(1'b0, DT_LARGE);
        m_dt = DT_LARGE;
        sector_seen = '0;
        for (int i = 0; i < NUM_DT; i++) begin
            gz = sample_t'(16384 + ($urandom() % 512));
            run_sample(random_sample(), random_sample(), gz);
        end
        check_value("sector_coverage", sector_seen, 16'hffff);

        // Second strobe lands in rotate_wait and must be dropped
        target = done_count + 1;
        drive_sample(random_sample(), random_sample(), random_sample());
        nav_model(acc_x, acc_y, gyro_z);
        repeat (2) @(posedge clk);
        drive_sample(random_sample(), random_sample(), random_sample());
        waited = 4;
        wait_for_done(target, waited);
        repeat (SPACING) @(posedge clk);

        // Clear while idle with run_en kept set
        cfg_write(1'b1, 16'h0003);
        repeat (2) @(posedge clk);
        m_heading = '0;
        m_vel_x   = '0;
        m_vel_y   = '0;
        m_pos_x   = '0;
        m_pos_y   = '0;
        check_published_zero();
        run_sample(random_sample(), random_sample(), random_sample());

        repeat (SPACING) @(posedge clk);
        run_done = 1'b1;
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* nav_chk.sv */
`timescale 1ns/1ps

module nav_chk (
    input logic clk,
    input logic rst,
    input logic sample_valid,
    input logic run_en,
    input logic busy,
    input logic heading_en,
    input logic update_done
);

    logic accepted;

    // Idle is the only state with busy and heading_en both low
    assign accepted = sample_valid && run_en && !busy && !heading_en;

    ////////////////////////////////////////////////////////////
    // Handshake properties
    ////////////////////////////////////////////////////////////

    done_one_cycle: assert property (
        @(posedge clk) disable iff (rst) update_done |=> !update_done
    ) else $error("update_done stayed high for more than one cycle");

    busy_falls_after_done: assert property (
        @(posedge clk) disable iff (rst) update_done |=> !busy
    ) else $error("busy still high in the cycle after update_done");

    busy_during_done: assert property (
        @(posedge clk) disable iff (rst) update_done |-> busy
    ) else $error("update_done pulsed while busy was low");

    // Accepted at edge E, done registered at edge E+6
    done_after_accept: assert property (
        @(posedge clk) disable iff (rst) update_done |-> $past(accepted, 7)
    ) else $error("update_done without an accepted sample six cycles earlier");

endmodule

bind nav_top nav_chk chk_i (
    .clk(clk), .rst(rst), .sample_valid(sample_valid), .run_en(run_en),
    .busy(busy), .heading_en(heading_en), .update_done(update_done)
);

/* nav_top.sv */
`timescale 1ns/1ps

module nav_top #(
    parameter nav_pkg::dt_t DT_RESET = 16'd1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             sample_valid,
    input  nav_pkg::sample_t acc_x,
    input  nav_pkg::sample_t acc_y,
    input  nav_pkg::sample_t gyro_z,
    input  logic             cfg_wr,
    input  logic             cfg_addr,
    input  logic [15:0]      cfg_data,
    output logic             busy,
    output logic             update_done,
    output nav_pkg::accum_t  heading,
    output nav_pkg::accum_t  vel_x,
    output nav_pkg::accum_t  vel_y,
    output nav_pkg::accum_t  pos_x,
    output nav_pkg::accum_t  pos_y
);

    import nav_pkg::*;

    dt_t     dt;
    logic    run_en;
    logic    clear;
    logic    acc_clear;
    logic    heading_en;
    logic    rot_start;
    logic    vel_en;
    logic    pos_en;
    sample_t sample_ax;
    sample_t sample_ay;
    sample_t sample_gz;
    accum_t  heading_acc;
    accum_t  rot_x;
    accum_t  rot_y;
    accum_t  vel_x_acc;
    accum_t  vel_y_acc;
    accum_t  pos_x_acc;
    accum_t  pos_y_acc;

    // Clear reaches the accumulators only while the sequencer is idle
    assign acc_clear = clear && !(busy || heading_en);

    nav_config #(.DT_RESET(DT_RESET)) config_i (
        .clk(clk), .rst(rst), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr),
        .cfg_data(cfg_data), .dt(dt), .run_en(run_en), .clear(clear)
    );

    nav_sequencer seq_i (
        .clk(clk), .rst(rst), .sample_valid(sample_valid),
        .acc_x(acc_x), .acc_y(acc_y), .gyro_z(gyro_z),
        .run_en(run_en), .clear(clear),
        .heading_acc(heading_acc), .vel_x_acc(vel_x_acc), .vel_y_acc(vel_y_acc),
        .pos_x_acc(pos_x_acc), .pos_y_acc(pos_y_acc),
        .busy(busy), .update_done(update_done),
        .heading_en(heading_en), .rot_start(rot_start), .vel_en(vel_en), .pos_en(pos_en),
        .sample_ax(sample_ax), .sample_ay(sample_ay), .sample_gz(sample_gz),
        .heading(heading), .vel_x(vel_x), .vel_y(vel_y), .pos_x(pos_x), .pos_y(pos_y)
    );

    // Sector is the top nibble of heading
    nav_rotator rot_i (
        .clk(clk), .rst(rst), .start(rot_start), .acc_x(sample_ax), .acc_y(sample_ay),
        .sector(heading_acc[31:28]), .rot_x(rot_x), .rot_y(rot_y)
    );

    nav_integrator heading_i (
        .clk(clk), .rst(rst), .clear(acc_clear), .en(heading_en),
        .a(accum_t'(sample_gz)), .dt(dt), .acc(heading_acc)
    );

    nav_integrator vel_x_i (
        .clk(clk), .rst(rst), .clear(acc_clear), .en(vel_en),
        .a(rot_x), .dt(dt), .acc(vel_x_acc)
    );

    nav_integrator vel_y_i (
        .clk(clk), .rst(rst), .clear(acc_clear), .en(vel_en),
        .a(rot_y), .dt(dt), .acc(vel_y_acc)
    );

    nav_integrator pos_x_i (
        .clk(clk), .rst(rst), .clear(acc_clear), .en(pos_en),
        .a(vel_x_acc), .dt(dt), .acc(pos_x_acc)
    );

    nav_integrator pos_y_i (
        .clk(clk), .rst(rst), .clear(acc_clear), .en(pos_en),
        .a(vel_y_acc), .dt(dt), .acc(pos_y_acc)
    );

endmodule

/* nav_sequencer.sv */
`timescale 1ns/1ps

module nav_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             sample_valid,
    input  nav_pkg::sample_t acc_x,
    input  nav_pkg::sample_t acc_y,
    input  nav_pkg::sample_t gyro_z,
    input  logic             run_en,
    input  logic             clear,
    input  nav_pkg::accum_t  heading_acc,
    input  nav_pkg::accum_t  vel_x_acc,
    input  nav_pkg::accum_t  vel_y_acc,
    input  nav_pkg::accum_t  pos_x_acc,
    input  nav_pkg::accum_t  pos_y_acc,
    output logic             busy,
    output logic             update_done,
    output logic             heading_en,
    output logic             rot_start,
    output logic             vel_en,
    output logic             pos_en,
    output nav_pkg::sample_t sample_ax,
    output nav_pkg::sample_t sample_ay,
    output nav_pkg::sample_t sample_gz,
    output nav_pkg::accum_t  heading,
    output nav_pkg::accum_t  vel_x,
    output nav_pkg::accum_t  vel_y,
    output nav_pkg::accum_t  pos_x,
    output nav_pkg::accum_t  pos_y
);

    import nav_pkg::*;

    seq_state_t state;
    seq_state_t state_next;
    logic       accept;
    logic       clear_ok;

    // Busy stays up one cycle past the return to idle
    assign accept   = sample_valid && run_en && (state == idle) && !busy;
    assign clear_ok = clear && (state == idle) && !busy;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (accept) begin
                    state_next = integ_heading;
                end
            end
            integ_heading: state_next = rotate;
            rotate:        state_next = rotate_wait;
            rotate_wait:   state_next = integ_vel;
            integ_vel:     state_next = integ_pos;
            integ_pos:     state_next = publish;
            publish:       state_next = idle;
            default:       state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            busy        <= 1'b0;
            update_done <= 1'b0;
        end else begin
            state       <= state_next;
            busy        <= (state != idle);
            update_done <= (state == publish);
        end
    end

    // One strobe per stage
    assign heading_en = (state == integ_heading);
    assign rot_start  = (state == rotate);
    assign vel_en     = (state == integ_vel);
    assign pos_en     = (state == integ_pos);

    // Sample held for the whole run
    always_ff @(posedge clk) begin
        if (accept) begin
            sample_ax <= acc_x;
            sample_ay <= acc_y;
            sample_gz <= gyro_z;
        end
    end

    ////////////////////////////////////////////////////////////
    // Published outputs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || clear_ok) begin
            heading <= '0;
            vel_x   <= '0;
            vel_y   <= '0;
            pos_x   <= '0;
            pos_y   <= '0;
        end else if (state == publish) begin
            heading <= heading_acc;
            vel_x   <= vel_x_acc;
            vel_y   <= vel_y_acc;
            pos_x   <= pos_x_acc;
            pos_y   <= pos_y_acc;
        end
    end

endmodule

/* nav_rotator.sv */
`timescale 1ns/1ps

module nav_rotator (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  nav_pkg::sample_t acc_x,
    input  nav_pkg::sample_t acc_y,
    input  nav_pkg::sector_t sector,
    output nav_pkg::accum_t  rot_x,
    output nav_pkg::accum_t  rot_y
);

    import nav_pkg::*;

    sector_t cos_idx;

    // Stage one registers
    sample_t sin_q;
    sample_t cos_q;
    sample_t ax_q;
    sample_t ay_q;
    logic    stage_valid;

    // Stage two products
    accum_t x_cos;
    accum_t y_sin;
    accum_t x_sin;
    accum_t y_cos;
    accum_t rot_diff;
    accum_t rot_sum;

    // Cosine leads sine by a quarter turn, wraps in four bits
    assign cos_idx = sector + sector_t'(NUM_SECTORS / 4);

    ////////////////////////////////////////////////////////////
    // Stage one: table lookup
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            sin_q <= SIN_TABLE[sector];
            cos_q <= SIN_TABLE[cos_idx];
            ax_q  <= acc_x;
            ay_q  <= acc_y;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= start;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage two: multiply and combine
    ////////////////////////////////////////////////////////////

    assign x_cos = ax_q * cos_q;
    assign y_sin = ay_q * sin_q;
    assign x_sin = ax_q * sin_q;
    assign y_cos = ay_q * cos_q;

    assign rot_diff = x_cos - y_sin;
    assign rot_sum  = x_sin + y_cos;

    // Drop the table's fraction bits, keeping the sign
    always_ff @(posedge clk) begin
        if (stage_valid) begin
            rot_x <= rot_diff >>> TRIG_FRAC_BITS;
            rot_y <= rot_sum >>> TRIG_FRAC_BITS;
        end
    end

endmodule

/* nav_integrator.sv */
`timescale 1ns/1ps

module nav_integrator (
    input  logic            clk,
    input  logic            rst,
    input  logic            clear,
    input  logic            en,
    input  nav_pkg::accum_t a,
    input  nav_pkg::dt_t    dt,
    output nav_pkg::accum_t acc
);

    import nav_pkg::*;

    accum_t step;

    // dt is unsigned, so a zero sign bit goes in front of it
    // Only the low 32 bits of the product survive
    assign step = a * $signed({1'b0, dt});

    ////////////////////////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            acc <= '0;
        end else if (en) begin
            acc <= acc + step;
        end
    end

endmodule

/* nav_config.sv */
`timescale 1ns/1ps

module nav_config #(
    parameter nav_pkg::dt_t DT_RESET = 16'd1
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         cfg_wr,
    input  logic         cfg_addr,
    input  logic [15:0]  cfg_data,
    output nav_pkg::dt_t dt,
    output logic         run_en,
    output logic         clear
);

    // Register map
    localparam logic ADDR_DT   = 1'b0;
    localparam logic ADDR_CTRL = 1'b1;

    logic wr_dt;
    logic wr_ctrl;

    assign wr_dt   = cfg_wr && (cfg_addr == ADDR_DT);
    assign wr_ctrl = cfg_wr && (cfg_addr == ADDR_CTRL);

    always_ff @(posedge clk) begin
        if (rst) begin
            dt     <= DT_RESET;
            run_en <= 1'b0;
            clear  <= 1'b0;
        end else begin
            // Control bit 1 is self-clearing, so clear lasts one cycle
            clear <= wr_ctrl && cfg_data[1];

            if (wr_dt) begin
                dt <= cfg_data;
            end

            if (wr_ctrl) begin
                run_en <= cfg_data[0];
            end
        end
    end

endmodule

/* nav_pkg.sv */
package nav_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////

    // Raw sensor reading
    typedef logic signed [15:0] sample_t;

    // Integration step
    typedef logic [15:0] dt_t;

    // Heading, rotated acceleration, velocity and position
    typedef logic signed [31:0] accum_t;

    // Top four bits of heading
    typedef logic [3:0] sector_t;

    ////////////////////////////////////////////////////////////
    // Sequencer states
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        idle,
        integ_heading,
        rotate,
        rotate_wait,
        integ_vel,
        integ_pos,
        publish
    } seq_state_t;

    ////////////////////////////////////////////////////////////
    // Trig table
    ////////////////////////////////////////////////////////////

    localparam int NUM_SECTORS    = 16;
    localparam int TRIG_FRAC_BITS = 14;

    // sin(k * 22.5 deg) scaled by 2^14
    localparam sample_t SIN_TABLE [NUM_SECTORS] = '{
        16'sd0,      16'sd6270,   16'sd11585,  16'sd15137,
        16'sd16384,  16'sd15137,  16'sd11585,  16'sd6270,
        16'sd0,      -16'sd6270,  -16'sd11585, -16'sd15137,
        -16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270
    };

endpackage
